//--- src/sigdecode_h_config.svh
`ifndef SIGDECODE_H_CONFIG_SVH
`define SIGDECODE_H_CONFIG_SVH

// Coefficients per polynomial
`define SDH_N 256

// Polynomials in the hint vector
`define SDH_K 8

// Upper bound on the total number of hints
`define SDH_OMEGA 75

// Word address width of the destination memory
`define SDH_ADDR_W 14

// Index bytes plus count bytes, padded to whole dwords
`define SDH_BUF_BYTES 84

`endif

//--- src/mldsa_mem_pkg.sv
`include "sigdecode_h_config.svh"

package mldsa_mem_pkg;

    // Word address into the coefficient memory
    typedef logic [`SDH_ADDR_W-1:0] mem_addr_t;

    // Only writes are issued by this stage
    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_WRITE = 2'b10
    } mem_rw_mode_e;

    typedef struct packed {
        mem_rw_mode_e rd_wr_en;
        mem_addr_t    addr;
    } mem_if_t;

    // Four 1-bit hint coefficients, lane 0 holds the lowest index
    typedef logic [3:0] mem_wr_data_t;

endpackage

//--- src/sigdecode_h_pkg.sv
package sigdecode_h_pkg;

    typedef logic [7:0]  hint_byte_t;
    typedef logic [7:0]  hint_count_t;
    typedef logic [31:0] hint_dword_t;

    // One bit per byte of a dword, set when the byte is an index of the current poly
    typedef logic [3:0]  lane_map_t;

    typedef logic [6:0]  buf_ptr_t;
    typedef logic [3:0]  poly_idx_t;

    typedef enum logic [1:0] {
        SDH_RD_IDLE,
        SDH_RD_INIT,
        SDH_RD_HINTSUM,
        SDH_RD_EXEC
    } sdh_read_state_e;

    typedef enum logic [1:0] {
        SDH_WR_IDLE,
        SDH_WR_INIT,
        SDH_WR_MEM
    } sdh_write_state_e;

endpackage

//--- src/sigdecode_h_hint_buf.sv
`include "sigdecode_h_config.svh"

module sigdecode_h_hint_buf (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         hint_wr_en,
    input  sigdecode_h_pkg::buf_ptr_t    hint_wr_addr,
    input  sigdecode_h_pkg::hint_byte_t  hint_wr_data,
    input  logic                         sigdecode_h_enable,
    input  sigdecode_h_pkg::buf_ptr_t    rd_ptr,
    input  logic                         hint_rd_en,
    input  sigdecode_h_pkg::lane_map_t   curr_poly_map,
    input  sigdecode_h_pkg::poly_idx_t   poly_count,
    input  logic                         sigdecode_h_done,
    output sigdecode_h_pkg::hint_dword_t hint_dword,
    output logic                         hint_dword_valid,
    output sigdecode_h_pkg::hint_count_t hintsum_i,
    output logic                         sigdecode_h_error
);

    sigdecode_h_pkg::hint_byte_t buf_mem [`SDH_BUF_BYTES];

    logic       count_err, order_err, unused_err;
    logic       done_q, done_rise;
    // Smallest legal value for the next index of the current poly
    logic [8:0] prev_bound, next_bound;

    // Contents are frozen while a run is in progress
    always_ff @(posedge clk) begin
        if (hint_wr_en && sigdecode_h_done) begin
            buf_mem[hint_wr_addr] <= hint_wr_data;
        end
        if (hint_rd_en) begin
            hint_dword <= {buf_mem[rd_ptr + 3], buf_mem[rd_ptr + 2],
                           buf_mem[rd_ptr + 1], buf_mem[rd_ptr]};
        end
    end

    // Per-poly count from the cumulative count bytes
    always_comb begin
        if (poly_count >= `SDH_K) begin
            hintsum_i = '0;
        end else if (poly_count == '0) begin
            hintsum_i = buf_mem[`SDH_OMEGA];
        end else begin
            hintsum_i = buf_mem[`SDH_OMEGA + poly_count] - buf_mem[`SDH_OMEGA + poly_count - 1];
        end
    end

    // ------------------------------------------------------------------------
    // Format checks
    // ------------------------------------------------------------------------
    always_comb begin
        count_err = 1'b0;
        for (int p = 0; p < `SDH_K; p++) begin
            if (buf_mem[`SDH_OMEGA + p] > `SDH_OMEGA) begin
                count_err = 1'b1;
            end
            if (p != 0 && buf_mem[`SDH_OMEGA + p] < buf_mem[`SDH_OMEGA + p - 1]) begin
                count_err = 1'b1;
            end
        end
    end

    // Bytes past the final cumulative count must be zero
    always_comb begin
        unused_err = 1'b0;
        for (int i = 0; i < `SDH_OMEGA; i++) begin
            if (i >= buf_mem[`SDH_OMEGA + `SDH_K - 1] && buf_mem[i] != '0) begin
                unused_err = 1'b1;
            end
        end
    end

    // Enabled lanes are contiguous from lane 0, each must exceed the one before
    always_comb begin
        next_bound = prev_bound;
        order_err  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (curr_poly_map[i]) begin
                if ({1'b0, hint_dword[8*i +: 8]} < next_bound) begin
                    order_err = 1'b1;
                end
                next_bound = {1'b0, hint_dword[8*i +: 8]} + 9'd1;
            end
        end
    end

    assign done_rise = sigdecode_h_done && !done_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hint_dword_valid  <= 1'b0;
            prev_bound        <= '0;
            done_q            <= 1'b1;
            sigdecode_h_error <= 1'b0;
        end else begin
            hint_dword_valid <= hint_rd_en;
            // Dwords of one poly arrive back to back, a gap means a new poly
            prev_bound       <= hint_dword_valid ? next_bound : '0;
            done_q           <= sigdecode_h_done;
            if (sigdecode_h_enable && sigdecode_h_done) begin
                sigdecode_h_error <= count_err;
            end else if ((hint_dword_valid && order_err) || (done_rise && unused_err)) begin
                sigdecode_h_error <= 1'b1;
            end
        end
    end

endmodule

//--- src/sigdecode_h_bitmap.sv
`include "sigdecode_h_config.svh"

module sigdecode_h_bitmap (
    input  logic                          clk,
    input  logic                          reset_n,
    input  sigdecode_h_pkg::hint_dword_t  hint_dword,
    input  logic                          hint_dword_valid,
    input  sigdecode_h_pkg::lane_map_t    curr_poly_map,
    input  logic                          rst_bitmap,
    input  logic [7:0]                    bitmap_ptr,
    output mldsa_mem_pkg::mem_wr_data_t   mem_wr_data
);

    sigdecode_h_pkg::hint_byte_t lane_idx [4];

    logic [`SDH_N-1:0] bitmap;
    logic [`SDH_N-1:0] set_mask;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_idx[i] = hint_dword[8*i +: 8];
        end
    end

    // One-hot bits for every index byte that belongs to the current poly
    always_comb begin
        set_mask = '0;
        for (int i = 0; i < 4; i++) begin
            if (hint_dword_valid && curr_poly_map[i]) begin
                set_mask[lane_idx[i]] = 1'b1;
            end
        end
    end

    // Clear wins, the next poly's indices only arrive after its write phase begins
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bitmap <= '0;
        end else if (rst_bitmap) begin
            bitmap <= '0;
        end else begin
            bitmap <= bitmap | set_mask;
        end
    end

    // Slice for the word being written this cycle
    assign mem_wr_data = bitmap[bitmap_ptr +: 4];

endmodule

//--- src/sigdecode_h_ctrl.sv
`include "sigdecode_h_config.svh"

module sigdecode_h_ctrl (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         sigdecode_h_enable,
    input  mldsa_mem_pkg::mem_addr_t     dest_base_addr,
    input  sigdecode_h_pkg::hint_count_t hintsum_i,
    input  logic                         sigdecode_h_error,
    output mldsa_mem_pkg::mem_if_t       mem_wr_req,
    output logic                         sigdecode_h_done,
    output sigdecode_h_pkg::poly_idx_t   poly_count,
    output sigdecode_h_pkg::buf_ptr_t    rd_ptr,
    output logic                         rst_bitmap,
    output sigdecode_h_pkg::lane_map_t   curr_poly_map,
    output logic [7:0]                   bitmap_ptr,
    output logic                         hint_rd_en
);

    localparam logic [7:0] last_slice = 8'(`SDH_N - 4);

    sigdecode_h_pkg::sdh_read_state_e  rd_state, rd_state_nxt;
    sigdecode_h_pkg::sdh_write_state_e wr_state, wr_state_nxt;

    mldsa_mem_pkg::mem_addr_t     mem_wr_addr;
    mldsa_mem_pkg::mem_rw_mode_e  rd_wr_en;
    sigdecode_h_pkg::hint_count_t rem_hintsum;
    sigdecode_h_pkg::lane_map_t   tail_map;

    logic start, latch_hintsum, incr_poly;
    logic poly_done_rd, poly_done_wr, last_poly;
    logic rd_exec_f;

    assign start        = sigdecode_h_enable && (wr_state == sigdecode_h_pkg::SDH_WR_IDLE);
    assign last_poly    = (poly_count == 4'(`SDH_K - 1));
    assign poly_done_rd = (rd_state == sigdecode_h_pkg::SDH_RD_EXEC) && (rem_hintsum == '0);
    assign poly_done_wr = (bitmap_ptr == last_slice);

    assign sigdecode_h_done = (rd_state == sigdecode_h_pkg::SDH_RD_IDLE) &&
                              (wr_state == sigdecode_h_pkg::SDH_WR_IDLE);

    // Lanes taken from a dword; fewer than four only on the last read of a poly
    always_comb begin
        case (rem_hintsum)
            8'd1:    tail_map = 4'b0001;
            8'd2:    tail_map = 4'b0011;
            8'd3:    tail_map = 4'b0111;
            default: tail_map = 4'b1111;
        endcase
    end

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rem_hintsum   <= '0;
            curr_poly_map <= '0;
            rd_ptr        <= '0;
            rd_exec_f     <= 1'b0;
        end else begin
            rd_exec_f <= (rd_state == sigdecode_h_pkg::SDH_RD_EXEC);
            if (latch_hintsum) begin
                rem_hintsum   <= hintsum_i;
                curr_poly_map <= '0;
            end else begin
                curr_poly_map <= hint_rd_en ? tail_map : '0;
                if (hint_rd_en) begin
                    rem_hintsum <= (rem_hintsum > 8'd4) ? rem_hintsum - 8'd4 : '0;
                end
            end
            if (start) begin
                rd_ptr <= '0;
            end else if (hint_rd_en) begin
                rd_ptr <= rd_ptr + ((rem_hintsum > 8'd4) ? 7'd4 : rem_hintsum[6:0]);
            end
        end
    end

    always_comb begin
        rd_state_nxt  = rd_state;
        latch_hintsum = 1'b0;
        hint_rd_en    = 1'b0;
        case (rd_state)
            sigdecode_h_pkg::SDH_RD_IDLE: begin
                if (sigdecode_h_enable) begin
                    rd_state_nxt = sigdecode_h_pkg::SDH_RD_INIT;
                end
            end
            // Hold until the write side has finished the previous poly
            sigdecode_h_pkg::SDH_RD_INIT: begin
                if (wr_state == sigdecode_h_pkg::SDH_WR_INIT) begin
                    rd_state_nxt = sigdecode_h_pkg::SDH_RD_HINTSUM;
                end
            end
            sigdecode_h_pkg::SDH_RD_HINTSUM: begin
                latch_hintsum = 1'b1;
                rd_state_nxt  = sigdecode_h_pkg::SDH_RD_EXEC;
            end
            sigdecode_h_pkg::SDH_RD_EXEC: begin
                if (poly_done_rd) begin
                    rd_state_nxt = last_poly ? sigdecode_h_pkg::SDH_RD_IDLE :
                                               sigdecode_h_pkg::SDH_RD_INIT;
                end else begin
                    hint_rd_en = 1'b1;
                end
            end
            default: rd_state_nxt = sigdecode_h_pkg::SDH_RD_IDLE;
        endcase
        if (sigdecode_h_error && rd_state != sigdecode_h_pkg::SDH_RD_IDLE) begin
            rd_state_nxt = sigdecode_h_pkg::SDH_RD_IDLE;
            hint_rd_en   = 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------
    always_comb begin
        wr_state_nxt = wr_state;
        rd_wr_en     = mldsa_mem_pkg::RW_IDLE;
        incr_poly    = 1'b0;
        case (wr_state)
            sigdecode_h_pkg::SDH_WR_IDLE: begin
                if (sigdecode_h_enable) begin
                    wr_state_nxt = sigdecode_h_pkg::SDH_WR_INIT;
                end
            end
            // First dword reaches the bitmap before the first word goes out
            sigdecode_h_pkg::SDH_WR_INIT: begin
                if (sigdecode_h_error) begin
                    wr_state_nxt = sigdecode_h_pkg::SDH_WR_IDLE;
                end else if (rd_exec_f) begin
                    wr_state_nxt = sigdecode_h_pkg::SDH_WR_MEM;
                end
            end
            sigdecode_h_pkg::SDH_WR_MEM: begin
                if (sigdecode_h_error) begin
                    wr_state_nxt = sigdecode_h_pkg::SDH_WR_IDLE;
                end else begin
                    rd_wr_en = mldsa_mem_pkg::RW_WRITE;
                    if (poly_done_wr) begin
                        incr_poly    = 1'b1;
                        wr_state_nxt = last_poly ? sigdecode_h_pkg::SDH_WR_IDLE :
                                                   sigdecode_h_pkg::SDH_WR_INIT;
                    end
                end
            end
            default: wr_state_nxt = sigdecode_h_pkg::SDH_WR_IDLE;
        endcase
    end

    // After an abort the pointer parks on the last slice for one idle cycle
    assign rst_bitmap = incr_poly ||
                        (wr_state == sigdecode_h_pkg::SDH_WR_IDLE && bitmap_ptr == last_slice);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state    <= sigdecode_h_pkg::SDH_RD_IDLE;
            wr_state    <= sigdecode_h_pkg::SDH_WR_IDLE;
            mem_wr_addr <= '0;
            bitmap_ptr  <= '0;
            poly_count  <= '0;
        end else begin
            rd_state <= rd_state_nxt;
            wr_state <= wr_state_nxt;

            if (wr_state == sigdecode_h_pkg::SDH_WR_IDLE) begin
                mem_wr_addr <= dest_base_addr;
            end else if (rd_wr_en == mldsa_mem_pkg::RW_WRITE) begin
                mem_wr_addr <= mem_wr_addr + 1'b1;
            end

            // Wraps to zero after the last slice
            if (sigdecode_h_error && wr_state != sigdecode_h_pkg::SDH_WR_IDLE) begin
                bitmap_ptr <= last_slice;
            end else if (wr_state == sigdecode_h_pkg::SDH_WR_IDLE) begin
                bitmap_ptr <= '0;
            end else if (rd_wr_en == mldsa_mem_pkg::RW_WRITE) begin
                bitmap_ptr <= bitmap_ptr + 8'd4;
            end

            if (start) begin
                poly_count <= '0;
            end else if (incr_poly) begin
                poly_count <= poly_count + 1'b1;
            end
        end
    end

    assign mem_wr_req = '{rd_wr_en: rd_wr_en, addr: mem_wr_addr};

endmodule

//--- src/sigdecode_h_top.sv
module sigdecode_h_top (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         sigdecode_h_enable,
    input  mldsa_mem_pkg::mem_addr_t     dest_base_addr,
    input  logic                         hint_wr_en,
    input  sigdecode_h_pkg::buf_ptr_t    hint_wr_addr,
    input  sigdecode_h_pkg::hint_byte_t  hint_wr_data,
    output mldsa_mem_pkg::mem_if_t       mem_wr_req,
    output mldsa_mem_pkg::mem_wr_data_t  mem_wr_data,
    output logic                         sigdecode_h_done,
    output logic                         sigdecode_h_error
);

    sigdecode_h_pkg::hint_dword_t hint_dword;
    sigdecode_h_pkg::hint_count_t hintsum_i;
    sigdecode_h_pkg::buf_ptr_t    rd_ptr;
    sigdecode_h_pkg::lane_map_t   curr_poly_map;
    sigdecode_h_pkg::poly_idx_t   poly_count;
    logic                         hint_dword_valid;
    logic                         hint_rd_en;
    logic                         rst_bitmap;
    logic [7:0]                   bitmap_ptr;

    sigdecode_h_hint_buf u_hint_buf (
        .clk                (clk),
        .reset_n            (reset_n),
        .hint_wr_en         (hint_wr_en),
        .hint_wr_addr       (hint_wr_addr),
        .hint_wr_data       (hint_wr_data),
        .sigdecode_h_enable (sigdecode_h_enable),
        .rd_ptr             (rd_ptr),
        .hint_rd_en         (hint_rd_en),
        .curr_poly_map      (curr_poly_map),
        .poly_count         (poly_count),
        .sigdecode_h_done   (sigdecode_h_done),
        .hint_dword         (hint_dword),
        .hint_dword_valid   (hint_dword_valid),
        .hintsum_i          (hintsum_i),
        .sigdecode_h_error  (sigdecode_h_error)
    );

    sigdecode_h_bitmap u_bitmap (
        .clk              (clk),
        .reset_n          (reset_n),
        .hint_dword       (hint_dword),
        .hint_dword_valid (hint_dword_valid),
        .curr_poly_map    (curr_poly_map),
        .rst_bitmap       (rst_bitmap),
        .bitmap_ptr       (bitmap_ptr),
        .mem_wr_data      (mem_wr_data)
    );

    sigdecode_h_ctrl u_ctrl (
        .clk                (clk),
        .reset_n            (reset_n),
        .sigdecode_h_enable (sigdecode_h_enable),
        .dest_base_addr     (dest_base_addr),
        .hintsum_i          (hintsum_i),
        .sigdecode_h_error  (sigdecode_h_error),
        .mem_wr_req         (mem_wr_req),
        .sigdecode_h_done   (sigdecode_h_done),
        .poly_count         (poly_count),
        .rd_ptr             (rd_ptr),
        .rst_bitmap         (rst_bitmap),
        .curr_poly_map      (curr_poly_map),
        .bitmap_ptr         (bitmap_ptr),
        .hint_rd_en         (hint_rd_en)
    );

endmodule

//--- verification/sigdecode_h_clkgen.sv
module sigdecode_h_clkgen #(
    parameter int period       = 8,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Released on a falling edge, clear of the sampling edge
    initial begin
        reset_n = 1'b0;
        #(reset_cycles * period);
        reset_n = 1'b1;
    end

endmodule

//--- verification/sigdecode_h_chk.sv
`include "sigdecode_h_config.svh"

module sigdecode_h_chk (
    input logic                              clk,
    input logic                              reset_n,
    input logic                              sigdecode_h_enable,
    input sigdecode_h_pkg::sdh_read_state_e  rd_state,
    input sigdecode_h_pkg::sdh_write_state_e wr_state,
    input mldsa_mem_pkg::mem_if_t            mem_wr_req,
    input logic                              rst_bitmap,
    input logic [7:0]                        bitmap_ptr,
    input logic                              sigdecode_h_done
);

    int unsigned fail_count = 0;

    // Writes only come out of an active write FSM that has passed through init
    write_needs_active: assert property (
        @(posedge clk) disable iff (!reset_n)
        (mem_wr_req.rd_wr_en == mldsa_mem_pkg::RW_WRITE) |->
            ((wr_state != sigdecode_h_pkg::SDH_WR_IDLE) &&
             ($past(wr_state) != sigdecode_h_pkg::SDH_WR_IDLE))
    ) else begin
        fail_count++;
        $error("write mode while the write FSM is idle or just left idle");
    end

    // Clear lands on the last slice and the pointer restarts at zero
    clear_on_last_slice: assert property (
        @(posedge clk) disable iff (!reset_n)
        rst_bitmap |-> (bitmap_ptr == 8'(`SDH_N - 4)) ##1 (bitmap_ptr == '0)
    ) else begin
        fail_count++;
        $error("bitmap cleared away from the last slice or pointer not restarted");
    end

    // Idle FSMs keep done high until the next enable
    idle_means_done: assert property (
        @(posedge clk) disable iff (!reset_n)
        (rd_state == sigdecode_h_pkg::SDH_RD_IDLE &&
         wr_state == sigdecode_h_pkg::SDH_WR_IDLE &&
         !sigdecode_h_enable) |-> sigdecode_h_done ##1 sigdecode_h_done
    ) else begin
        fail_count++;
        $error("done low with both FSMs idle and no enable");
    end

endmodule

bind sigdecode_h_ctrl sigdecode_h_chk u_chk (
    .clk                (clk),
    .reset_n            (reset_n),
    .sigdecode_h_enable (sigdecode_h_enable),
    .rd_state           (rd_state),
    .wr_state           (wr_state),
    .mem_wr_req         (mem_wr_req),
    .rst_bitmap         (rst_bitmap),
    .bitmap_ptr         (bitmap_ptr),
    .sigdecode_h_done   (sigdecode_h_done)
);

//--- verification/sigdecode_h_tb.sv
`include "sigdecode_h_config.svh"

module sigdecode_h_tb;

    localparam int num_tests       = 6;
    localparam int field_bytes     = `SDH_OMEGA + `SDH_K;
    // Base address, hint field, expected error flag
    localparam int record_words    = field_bytes + 2;
    localparam int writes_per_poly = `SDH_N / 4;
    localparam int timeout_cycles  = num_tests * 1200;

    typedef struct packed {
        logic       count_bad;
        logic       order_bad;
        logic       unused_bad;
        logic [3:0] order_poly;
    } fault_t;

    logic                        clk;
    logic                        reset_n;
    logic                        sigdecode_h_enable;
    mldsa_mem_pkg::mem_addr_t    dest_base_addr;
    logic                        hint_wr_en;
    sigdecode_h_pkg::buf_ptr_t   hint_wr_addr;
    sigdecode_h_pkg::hint_byte_t hint_wr_data;
    mldsa_mem_pkg::mem_if_t      mem_wr_req;
    mldsa_mem_pkg::mem_wr_data_t mem_wr_data;
    logic                        sigdecode_h_done;
    logic                        sigdecode_h_error;

    logic [15:0]                 golden [num_tests * record_words];
    sigdecode_h_pkg::hint_byte_t field [field_bytes];
    logic [`SDH_N-1:0]           exp_map [`SDH_K];
    fault_t                      fault;
    mldsa_mem_pkg::mem_addr_t    cur_base;
    logic                        exp_err;

    int checks       = 0;
    int errors       = 0;
    int cycles       = 0;
    int write_count  = 0;
    int assert_fails = 0;

    sigdecode_h_clkgen #(
        .period       (8),
        .reset_cycles (3)
    ) u_clkgen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    sigdecode_h_top u_dut (
        .clk                (clk),
        .reset_n            (reset_n),
        .sigdecode_h_enable (sigdecode_h_enable),
        .dest_base_addr     (dest_base_addr),
        .hint_wr_en         (hint_wr_en),
        .hint_wr_addr       (hint_wr_addr),
        .hint_wr_data       (hint_wr_data),
        .mem_wr_req         (mem_wr_req),
        .mem_wr_data        (mem_wr_data),
        .sigdecode_h_done   (sigdecode_h_done),
        .sigdecode_h_error  (sigdecode_h_error)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic void build_model();
        int lo;
        int hi;
        lo    = 0;
        fault = '0;
        for (int p = 0; p < `SDH_K; p++) begin
            hi         = field[`SDH_OMEGA + p];
            exp_map[p] = '0;
            if (hi > `SDH_OMEGA || hi < lo) begin
                fault.count_bad = 1'b1;
            end
            for (int i = lo; i < hi && i < `SDH_OMEGA; i++) begin
                exp_map[p][field[i]] = 1'b1;
                // First poly whose indices fail to rise strictly
                if (i > lo && field[i] <= field[i - 1] && !fault.order_bad) begin
                    fault.order_bad  = 1'b1;
                    fault.order_poly = 4'(p);
                end
            end
            lo = hi;
        end
        for (int i = field[field_bytes - 1]; i < `SDH_OMEGA; i++) begin
            if (field[i] != '0) begin
                fault.unused_bad = 1'b1;
            end
        end
    endfunction

    task automatic load_field();
        for (int i = 0; i < field_bytes; i++) begin
            @(negedge clk);
            hint_wr_en   = 1'b1;
            hint_wr_addr = sigdecode_h_pkg::buf_ptr_t'(i);
            hint_wr_data = field[i];
        end
        @(negedge clk);
        hint_wr_en = 1'b0;
    endtask

    task automatic run_test(input int t);
        int rec;
        rec      = t * record_words;
        cur_base = golden[rec][`SDH_ADDR_W-1:0];
        for (int i = 0; i < field_bytes; i++) begin
            field[i] = golden[rec + 1 + i][7:0];
        end
        exp_err = golden[rec + 1 + field_bytes][0];
        build_model();
        check_value(fault.count_bad | fault.order_bad | fault.unused_bad, exp_err,
                    "golden error flag against the hint rules");
        load_field();

        write_count = 0;
        @(negedge clk);
        dest_base_addr     = cur_base;
        sigdecode_h_enable = 1'b1;
        @(negedge clk);
        sigdecode_h_enable = 1'b0;
        check_value(sigdecode_h_done, 1'b0, "done while running");
        while (!sigdecode_h_done) begin
            @(negedge clk);
        end
        // Unused-byte error lands one cycle after done rises
        repeat (2) @(negedge clk);
        check_value(sigdecode_h_done, 1'b1, "done after the run");
        check_value(sigdecode_h_error, exp_err, "error flag");

        if (fault.count_bad) begin
            check_value(write_count <= writes_per_poly, 1'b1, "writes after a bad count");
        end else if (fault.order_bad) begin
            check_value(write_count / writes_per_poly, fault.order_poly,
                        "polynomials written before the index fault");
        end else begin
            check_value(write_count, `SDH_K * writes_per_poly, "number of writes");
        end
    endtask

    // Scoreboard on the write port, sampled mid-cycle
    always @(negedge clk) begin : scoreboard
        int poly;
        int slice;
        if (reset_n && mem_wr_req.rd_wr_en == mldsa_mem_pkg::RW_WRITE) begin
            poly  = write_count / writes_per_poly;
            slice = write_count % writes_per_poly;
            if (poly >= `SDH_K) begin
                errors++;
                $display("Write seen after the last polynomial was complete, at time %0t",
                         $time);
            end else begin
                check_value(mem_wr_req.addr,
                            mldsa_mem_pkg::mem_addr_t'(cur_base + write_count),
                            "write address");
                check_value(mem_wr_data, exp_map[poly][4*slice +: 4], "write data");
            end
            write_count++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (cycles >= timeout_cycles);
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Test failures found");
        $finish;
    end

    initial begin
        sigdecode_h_enable = 1'b0;
        dest_base_addr     = '0;
        hint_wr_en         = 1'b0;
        hint_wr_addr       = '0;
        hint_wr_data       = '0;
        $readmemh("verification/sigdecode_h_golden.txt", golden);

        wait (reset_n === 1'b1);
        @(negedge clk);
        check_value(sigdecode_h_done, 1'b1, "done after reset");
        check_value(sigdecode_h_error, 1'b0, "error after reset");
        check_value(mem_wr_req.rd_wr_en, mldsa_mem_pkg::RW_IDLE, "access mode after reset");

        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end

        assert_fails = u_dut.u_ctrl.u_chk.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+src
src/mldsa_mem_pkg.sv
src/sigdecode_h_pkg.sv
src/sigdecode_h_hint_buf.sv
src/sigdecode_h_bitmap.sv
src/sigdecode_h_ctrl.sv
src/sigdecode_h_top.sv
verification/sigdecode_h_clkgen.sv
verification/sigdecode_h_chk.sv
verification/sigdecode_h_tb.sv

//--- Bender.yml
package:
  name: sigdecode_h

sources:
  - include_dirs:
      - src
    files:
      - src/mldsa_mem_pkg.sv
      - src/sigdecode_h_pkg.sv
      - src/sigdecode_h_hint_buf.sv
      - src/sigdecode_h_bitmap.sv
      - src/sigdecode_h_ctrl.sv
      - src/sigdecode_h_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/sigdecode_h_clkgen.sv
      - verification/sigdecode_h_chk.sv
      - verification/sigdecode_h_tb.sv

//--- verification/sigdecode_h_golden.txt
// Per test: base address, 75 index bytes in three rows of 25,
// then 8 cumulative hint counts followed by the expected error flag
0100 // sparse hints
03 C8 00 07 40 FF 80 01 02 FA 11 21 63 05 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
02 03 06 07 09 0A 0D 0E 0
0800 // empty polys, nine hints from an unaligned start
0A 14 00 04 05 08 0C 40 80 C0 FE 03 04 0B 10 64 FF 80 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 02 0B 0B 0B 11 11 12 0
0200 // count drops at poly 2
01 02 03 04 05 06 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
02 05 04 06 06 06 06 06 1
1000 // repeated index in poly 1
02 30 0A 0A 05 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
02 04 05 05 05 05 05 05 1
0040 // last unused index byte nonzero
7F 01 02 03 04 05 10 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 33
01 01 01 06 06 06 06 07 1
3C00 // clean run after the faulty ones
00 01 02 03 FC FD FE FF 80 10 20 30 40 50 60 70 01 FF 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
04 08 09 09 10 10 10 12 0
